/* filelist.f */
+incdir+logic
logic/rf_pkg.sv
logic/div_pkg.sv
logic/div_core.sv
logic/div_wb_ctrl.sv
logic/reg_file.sv
logic/int_div_regfile_top.sv
test/tb_int_div_regfile.sv

/* Bender.yml */
package:
  name: int_div_regfile

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rf_pkg.sv
      - logic/div_pkg.sv
      - logic/div_core.sv
      - logic/div_wb_ctrl.sv
      - logic/reg_file.sv
      - logic/int_div_regfile_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_int_div_regfile.sv

/* test/tb_int_div_regfile.sv */
// ==================================================
// Self-checking testbench for the divide path. Runs
// directed and random divides, mirrors each write in
// a shadow register array and reads every register
// back over the read port after each operation.
// ==================================================

`timescale 1ns/100ps

`include "div_params.svh"

module tb_int_div_regfile import rf_pkg::*, div_pkg::*;;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_OPS         = 11;                       // Divides over all tests.
    localparam int OP_CYCLES       = 40 + `DIV_NUM_REGS + 2;   // Divide, then full readback.
    localparam int WATCHDOG_CYCLES = (NUM_OPS + 1) * OP_CYCLES + 20;

    logic     clk;
    logic     rst;
    logic     req;
    logic     busy;
    data_t    a;
    data_t    b;
    reg_sel_t r_quot_sel;
    reg_sel_t r_mod_sel;
    reg_sel_t rd_sel;
    data_t    rd_data;

    data_t       shadow [`DIV_NUM_REGS];  // Expected register contents.
    logic [31:0] rng;                     // Random state.
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          err_base;                // Error count when the current test began.
    int          busy_len;                // Clocks that busy has been seen high.
    int          exp_busy_len;            // Busy length of the accepted request.

    int_div_regfile_top u_dut (
        .clk, .rst, .req, .busy, .a, .b, .r_quot_sel, .r_mod_sel, .rd_sel, .rd_data
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) busy_len <= 0;
        else if (busy) busy_len <= busy_len + 1; // Old busy, as the DUT updates it late.
        else busy_len <= 0;
    end

    // An accepted request must raise busy on the accepting edge.
    a_busy_rise : assert property (@(posedge clk) disable iff (rst) req && !busy |=> busy)
        else begin
            $display("** Error at %0t: busy did not rise after an accepted req", $time);
            errors = errors + 1;
        end

    // Busy only rises in answer to a request.
    a_busy_cause : assert property (@(posedge clk) disable iff (rst) $rose(busy) |-> $past(req))
        else begin
            $display("** Error at %0t: busy rose without a req", $time);
            errors = errors + 1;
        end

    // Busy falls a fixed number of clocks after accept, set by the selectors.
    a_busy_len : assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> busy_len == exp_busy_len)
        else begin
            $display("** Error at %0t: busy lasted %0d cycles, expected %0d",
                     $time, busy_len, exp_busy_len);
            errors = errors + 1;
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Every nonzero selector costs one two-cycle write after the 32 steps.
    function automatic int busy_cycles(input reg_sel_t qs, input reg_sel_t ms);
        return `DIV_DATA_WIDTH + ((qs != ZERO_SEL) ? 2 : 0) + ((ms != ZERO_SEL) ? 2 : 0);
    endfunction

    task automatic apply_to_shadow(input data_t op_a, input data_t op_b,
                                   input reg_sel_t qs, input reg_sel_t ms);
        data_t q;
        data_t r;
        if (op_b == '0) begin
            q = '1;      // Restoring rule for a zero divisor.
            r = op_a;
        end else begin
            q = op_a / op_b;
            r = op_a % op_b;
        end
        if (qs != ZERO_SEL) shadow[qs] = q;
        if (ms != ZERO_SEL) shadow[ms] = r; // Written second, so it wins a shared register.
    endtask

    task automatic start_div(input data_t op_a, input data_t op_b,
                             input reg_sel_t qs, input reg_sel_t ms);
        @(posedge clk);
        #2;
        req          = 1'b1;
        a            = op_a;
        b            = op_b;
        r_quot_sel   = qs;
        r_mod_sel    = ms;
        exp_busy_len = busy_cycles(qs, ms);
        @(posedge clk);
        #2;
        req        = 1'b0;
        a          = ~op_a;     // The DUT must already hold its own copies.
        r_quot_sel = ZERO_SEL;
        r_mod_sel  = ZERO_SEL;
        apply_to_shadow(op_a, op_b, qs, ms);
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_regs();
        for (int i = 0; i < `DIV_NUM_REGS; i++) begin
            @(posedge clk);
            #2 rd_sel = reg_sel_t'(i);
            @(negedge clk);                 // Read data is settled mid-cycle.
            assert (rd_data === shadow[i]) else begin
                $display("** Error at %0t: register %0d reads %h, expected %h",
                         $time, i, rd_data, shadow[i]);
                errors = errors + 1;
            end
        end
    endtask

    task automatic run_div(input data_t op_a, input data_t op_b,
                           input reg_sel_t qs, input reg_sel_t ms);
        start_div(op_a, op_b, qs, ms);
        wait_idle();
        check_regs();
    endtask

    task automatic end_test(input string name);
        tests_run = tests_run + 1;
        if (errors != err_base) tests_failed = tests_failed + 1;
        $display("test %-16s %s", name, (errors == err_base) ? "ok" : "FAILED");
        err_base = errors;
    endtask

    initial begin
        data_t    op_a;
        data_t    op_b;
        reg_sel_t qs;
        reg_sel_t ms;
        rst          = 1'b1;
        req          = 1'b0;
        a            = '0;
        b            = '0;
        r_quot_sel   = ZERO_SEL;
        r_mod_sel    = ZERO_SEL;
        rd_sel       = ZERO_SEL;
        rng          = 32'h8bbe76d6;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_base     = 0;
        exp_busy_len = 0;
        for (int i = 0; i < `DIV_NUM_REGS; i++) shadow[i] = '0;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;

        // Reset state: idle, not busy, every register zero.
        assert (!busy && u_dut.u_ctrl.state == IDLE) else begin
            $display("** Error at %0t: DUT not idle after reset", $time);
            errors = errors + 1;
        end
        check_regs();
        end_test("reset_state");

        for (int n = 0; n < 4; n++) begin
            rng  = xorshift32(rng);
            op_a = rng;
            rng  = xorshift32(rng);
            op_b = rng >> rng[4:0];          // Spread divisor sizes widely.
            if (op_b == '0) op_b = 1;
            rng  = xorshift32(rng);
            qs   = reg_sel_t'(rng[4:0]);
            if (qs == ZERO_SEL) qs = 1;
            ms   = reg_sel_t'(qs + 1 + rng[7:5]);
            if (ms == ZERO_SEL) ms = (qs == 1) ? reg_sel_t'(2) : reg_sel_t'(1);
            run_div(op_a, op_b, qs, ms);
        end
        end_test("random_divide");

        run_div(32'd1000, 32'd7, 5'd3, ZERO_SEL);
        run_div(32'd1000, 32'd9, ZERO_SEL, 5'd4);
        run_div(32'hdead_beef, 32'd5, ZERO_SEL, ZERO_SEL);
        end_test("selector_skip");

        run_div(32'h1234_5678, 32'd0, 5'd20, 5'd21);
        end_test("divide_by_zero");

        run_div(32'd77, 32'd10, ZERO_SEL, 5'd6);
        run_div(32'd500, 32'd33, 5'd9, 5'd9);
        end_test("zero_and_shared");

        // A second req in the middle of CALC is dropped.
        start_div(32'd4000, 32'd13, 5'd11, 5'd12);
        repeat (10) @(posedge clk);
        #2;
        req        = 1'b1;
        a          = 32'd99;
        b          = 32'd2;
        r_quot_sel = 5'd11;
        r_mod_sel  = 5'd14;
        @(posedge clk);
        #2 req = 1'b0;
        wait_idle();
        check_regs();
        end_test("req_while_busy");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the run did not finish in time, the DUT may be stuck.");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* logic/int_div_regfile_top.sv */
// ================================================
// Top of the divide path: writeback controller,
// divider datapath and register file. The client
// strobes req; results are read back over rd_sel.
// ================================================

`timescale 1ns/100ps

module int_div_regfile_top
    import rf_pkg::*, div_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req,
    output logic     busy,
    input  data_t    a,
    input  data_t    b,
    input  reg_sel_t r_quot_sel,
    input  reg_sel_t r_mod_sel,
    input  reg_sel_t rd_sel,
    output data_t    rd_data
);

    logic     div_load;    // Controller to divider.
    logic     div_step;
    bit_pos_t pos;
    data_t    quotient;    // Divider results back to the controller.
    data_t    remainder;
    logic     rf_wr_req;   // Write port between controller and register file.
    reg_sel_t rf_wr_sel;
    data_t    rf_wr_data;
    logic     rf_wr_ack;

    div_wb_ctrl u_ctrl (
        .clk, .rst, .req, .busy, .r_quot_sel, .r_mod_sel,
        .div_load, .div_step, .pos, .quotient, .remainder,
        .rf_wr_req, .rf_wr_sel, .rf_wr_data, .rf_wr_ack
    );

    div_core u_core (
        .clk, .rst, .div_load, .div_step, .pos, .a, .b, .quotient, .remainder
    );

    reg_file u_rf (
        .clk, .rst, .rf_wr_req, .rf_wr_sel, .rf_wr_data, .rf_wr_ack, .rd_sel, .rd_data
    );

endmodule

/* logic/reg_file.sv */
// ================================================
// Register file with a hard-wired zero register.
// One req/ack write port, acked a cycle after req,
// and one combinational read port.
// ================================================

`timescale 1ns/100ps

`include "div_params.svh"

module reg_file
    import rf_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     rf_wr_req,
    input  reg_sel_t rf_wr_sel,
    input  data_t    rf_wr_data,
    output logic     rf_wr_ack,   // High for one cycle per write.
    input  reg_sel_t rd_sel,
    output data_t    rd_data
);

    data_t regs [`DIV_NUM_REGS];  // Entry 0 exists but is never written.
    logic  wr_take;               // A request not yet acked.

    // A request seen while ack is already high is the one just served.
    assign wr_take = rf_wr_req && !rf_wr_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rf_wr_ack <= 1'b0;
        end else begin
            rf_wr_ack <= wr_take;
        end
    end

    // Data lands on the same edge that raises ack.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `DIV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_take && rf_wr_sel != ZERO_SEL) begin
            regs[rf_wr_sel] <= rf_wr_data;
        end
    end

    assign rd_data = (rd_sel == ZERO_SEL) ? '0 : regs[rd_sel]; // Register 0 reads zero.

    // The writer holds req through the ack cycle, so a lone ack means a lost request.
    a_ack_with_req : assert property (
        @(posedge clk) disable iff (rst)
        rf_wr_ack |-> rf_wr_req
    );

endmodule

/* logic/div_wb_ctrl.sv */
// ================================================
// Writeback FSM for the divide path. Accepts a
// request, steps the divider for DIV_DATA_WIDTH
// clocks, then writes quotient and remainder over
// the rf_wr req/ack port, skipping zero selectors.
// ================================================

`timescale 1ns/100ps

`include "div_params.svh"

module div_wb_ctrl
    import rf_pkg::*, div_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req,         // One-cycle strobe from the client.
    output logic     busy,        // High from the accepting edge until done.
    input  reg_sel_t r_quot_sel,
    input  reg_sel_t r_mod_sel,
    output logic     div_load,
    output logic     div_step,
    output bit_pos_t pos,
    input  data_t    quotient,
    input  data_t    remainder,
    output logic     rf_wr_req,
    output reg_sel_t rf_wr_sel,
    output data_t    rf_wr_data,
    input  logic     rf_wr_ack
);

    div_state_e state;
    div_state_e next_state;
    reg_sel_t   quot_sel;  // Selectors held for the whole operation.
    reg_sel_t   mod_sel;
    logic       accept;

    assign accept   = req && !busy;   // Requests during an operation are dropped.
    assign div_load = accept;         // Operands land in the divider on the accepting edge.
    assign div_step = (state == CALC);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) next_state = CALC;
            end
            CALC: begin
                // The step at pos 0 is the last one.
                if (pos == '0) begin
                    if (quot_sel != ZERO_SEL)     next_state = WR_QUOT;
                    else if (mod_sel != ZERO_SEL) next_state = WR_MOD;
                    else                          next_state = IDLE;
                end
            end
            WR_QUOT: begin
                if (rf_wr_ack) next_state = (mod_sel != ZERO_SEL) ? WR_MOD : IDLE;
            end
            WR_MOD: begin
                if (rf_wr_ack) next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            busy     <= 1'b0;
            pos      <= '0;
            quot_sel <= ZERO_SEL;
            mod_sel  <= ZERO_SEL;
        end else begin
            state <= next_state;
            busy  <= (next_state != IDLE);  // Rises with the move to CALC.
            if (accept) begin
                pos      <= bit_pos_t'(`DIV_DATA_WIDTH - 1); // Start at the top bit.
                quot_sel <= r_quot_sel;
                mod_sel  <= r_mod_sel;
            end else if (state == CALC && pos != '0) begin
                pos <= pos - 1'b1;
            end
        end
    end

    // Request and payload come straight from state, so they hold until ack moves it on.
    assign rf_wr_req  = (state == WR_QUOT) || (state == WR_MOD);
    assign rf_wr_sel  = (state == WR_QUOT) ? quot_sel : mod_sel;
    assign rf_wr_data = (state == WR_QUOT) ? quotient : remainder;

    // A pending write must not change under the register file.
    a_wr_hold : assert property (
        @(posedge clk) disable iff (rst)
        rf_wr_req && !rf_wr_ack |=> rf_wr_req && $stable(rf_wr_sel) && $stable(rf_wr_data)
    );

    // The client must see busy until the last step or the last write ack is done.
    a_busy_state : assert property (
        @(posedge clk) disable iff (rst)
        $fell(busy) |-> $past(rf_wr_ack || (div_step && pos == '0))
    );

endmodule

/* logic/div_core.sv */
// ================================================
// Restoring shift-subtract divider datapath.
// Load with div_load, then hold div_step high while
// pos counts down; one quotient bit per clock.
// ================================================

`timescale 1ns/100ps

`include "div_params.svh"

module div_core
    import rf_pkg::*, div_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     div_load,  // Captures a and b, clears the quotient.
    input  logic     div_step,  // Decides the quotient bit at pos.
    input  bit_pos_t pos,
    input  data_t    a,
    input  data_t    b,
    output data_t    quotient,
    output data_t    remainder
);

    data_t  part_rem;      // Partial remainder, ends as the final remainder.
    data_t  divisor;       // Divisor held for the whole operation.
    data_t  quot;          // Quotient, built from the top bit down.
    dword_t shifted_div;   // Divisor moved up to the current bit position.
    dword_t wide_rem;      // Partial remainder widened for the compare.
    logic   fits;          // Shifted divisor does not exceed the remainder.

    // The compare runs at double width so bits shifted past the top are kept.
    assign shifted_div = dword_t'(divisor) << pos;
    assign wide_rem    = dword_t'(part_rem);
    assign fits        = (wide_rem >= shifted_div); // Always true for a zero divisor.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            part_rem <= '0;
            divisor  <= '0;
            quot     <= '0;
        end else if (div_load) begin
            part_rem <= a;           // The dividend starts as the remainder.
            divisor  <= b;
            quot     <= '0;          // Bits not set later stay zero.
        end else if (div_step) begin
            if (fits) begin
                // Upper bits of shifted_div are zero here, so the low word is exact.
                part_rem  <= part_rem - shifted_div[`DIV_DATA_WIDTH-1:0];
                quot[pos] <= 1'b1;
            end
        end
    end

    assign quotient  = quot;     // Valid once the step at pos 0 has landed.
    assign remainder = part_rem;

    // A load in the middle of a division would corrupt the running result.
    // The controller only loads from IDLE and only steps in CALC.
    a_no_load_during_step : assert property (
        @(posedge clk) disable iff (rst)
        !(div_load && div_step)
    );

endmodule

/* logic/div_pkg.sv */
// ================================================
// Divider control types: the writeback FSM states
// and the types used by each shift-subtract step.
// ================================================

`include "div_params.svh"

package div_pkg;

    // Controller state, two bits wide.
    typedef enum logic [1:0] {
        IDLE,    // Waiting for a request.
        CALC,    // One quotient bit per clock.
        WR_QUOT, // Quotient write in flight.
        WR_MOD   // Remainder write in flight.
    } div_state_e;

    // Position of the quotient bit being decided.
    typedef logic [`DIV_POS_WIDTH-1:0] bit_pos_t;

    // Double-width word for the shifted divisor compare.
    typedef logic [2*`DIV_DATA_WIDTH-1:0] dword_t;

endpackage

/* logic/rf_pkg.sv */
// ================================================
// Register file types shared by the divider, the
// writeback controller and the register file.
// Import with rf_pkg::* in the module header.
// ================================================

`include "div_params.svh"

package rf_pkg;

    // One register-wide word.
    typedef logic [`DIV_DATA_WIDTH-1:0] data_t;

    // Register selector; zero names the hard-wired zero register.
    typedef logic [`DIV_SEL_WIDTH-1:0] reg_sel_t;

    // Selector of the zero register, also the "do not write" code.
    localparam reg_sel_t ZERO_SEL = '0;

endpackage

/* logic/div_params.svh */
// ================================================
// Sizing macros for the integer divide path.
// Included by the packages and by any module that
// needs a raw width or count.
// ================================================

`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// Operand width, which is also the register width.
`define DIV_DATA_WIDTH 32

// Registers in the file, register 0 included.
`define DIV_NUM_REGS 32

// Selector width, log2 of DIV_NUM_REGS.
`define DIV_SEL_WIDTH 5

// Width of the quotient bit-position counter.
`define DIV_POS_WIDTH 5

`endif
